//--- flist.f
+incdir+verilog
verilog/usb_ep_pkg.sv
verilog/apb_pkg.sv
verilog/ep_fifo.sv
verilog/out_ep_receiver.sv
verilog/in_ep_packetizer.sv
verilog/serial_ep_regs.sv
verilog/usb_serial_bridge.sv
tests/usb_serial_bridge_asserts.sv
tests/usb_serial_bridge_tb.sv

//--- tests/usb_serial_bridge_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_serial_settings.svh"

module usb_serial_bridge_tb;

  // total test length is a few hundred cycles
  localparam int TIMEOUT_CYCLES = 4000;

  logic                    clk;
  logic                    rst_n;
  usb_ep_pkg::out_ep_in_t  out_ep_in;
  usb_ep_pkg::in_ep_in_t   in_ep_in;
  logic [7:0]              tx_data;
  logic                    tx_valid;
  logic                    rx_ready;
  apb_pkg::apb_req_t       apb_req;
  usb_ep_pkg::out_ep_out_t out_ep_out;
  usb_ep_pkg::in_ep_out_t  in_ep_out;
  logic                    tx_ready;
  usb_ep_pkg::rx_beat_t    rx_beat;
  logic                    rx_valid;
  apb_pkg::apb_rsp_t       apb_rsp;

  // scoreboards and host-side stimulus
  usb_ep_pkg::rx_beat_t host_q[$];
  usb_ep_pkg::rx_beat_t rx_exp_q[$];
  logic [7:0]           tx_exp_q[$];

  logic [31:0] lcg_state;
  string       test_name;
  int          out_sent;
  int          cycle_count;

  usb_serial_bridge dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .out_ep_in  (out_ep_in),
    .in_ep_in   (in_ep_in),
    .tx_data    (tx_data),
    .tx_valid   (tx_valid),
    .rx_ready   (rx_ready),
    .apb_req    (apb_req),
    .out_ep_out (out_ep_out),
    .in_ep_out  (in_ep_out),
    .tx_ready   (tx_ready),
    .rx_beat    (rx_beat),
    .rx_valid   (rx_valid),
    .apb_rsp    (apb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // in-endpoint core grants whenever the bridge asks
  always @(negedge clk) begin
    in_ep_in.grant = in_ep_out.req;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (dut0.asserts0.fail_count != 0) begin
      $display("a bound assertion failed before cycle %0d", cycle_count);
      $display("Verification failed");
      $fatal(1, "assertion failure");
    end else if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: tests still running after %0d clock cycles", cycle_count);
      $display("Verification failed");
      $fatal(1, "simulation timed out");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s (%s): expected 0x%0h, actual 0x%0h",
               test_name, what, expected, actual);
      $display("Verification failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // two-phase apb access, the completer never inserts a wait state
  task automatic apb_access(input logic [7:0] addr, input logic write, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clk);
    apb_req.penable = 1'b1;
    #1;
    check("pready", 1'b1, apb_rsp.pready);
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(negedge clk);
    apb_req = '0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata, output logic err);
    logic [31:0] unused;
    apb_access(addr, 1'b1, wdata, unused, err);
  endtask

  task automatic read_expect(input string what, input logic [7:0] addr,
                             input logic [31:0] expected);
    logic [31:0] rd;
    logic        err;
    apb_access(addr, 1'b0, 32'd0, rd, err);
    check({what, " pslverr"}, 1'b0, err);
    check(what, expected, rd);
  endtask

  // random bytes with random setup flags for the host and the scoreboard
  task automatic queue_out_beats(input int n);
    usb_ep_pkg::rx_beat_t beat;
    logic [31:0]          r;
    int                   i;
    for (i = 0; i < n; i++) begin
      r          = lcg_next();
      beat.data  = r[23:16];
      beat.setup = r[31];
      host_q.push_back(beat);
      rx_exp_q.push_back(beat);
    end
  endtask

  // out-endpoint core, drives each byte the cycle after its transfer
  task automatic out_host();
    usb_ep_pkg::rx_beat_t cur;
    logic                 pending;
    pending  = 1'b0;
    out_sent = 0;
    while (host_q.size() > 0 || pending) begin
      @(negedge clk);
      out_ep_in.setup      = pending ? cur.setup : 1'b0;
      out_ep_in.data       = pending ? cur.data : 8'h00;
      out_ep_in.grant      = 1'b1;
      out_ep_in.data_avail = (host_q.size() > 0);
      #1;
      check("data_get", out_ep_in.grant, out_ep_out.data_get);
      pending = out_ep_in.data_avail && out_ep_out.req;
      if (pending) begin
        cur = host_q.pop_front();
        out_sent++;
      end
    end
    @(negedge clk);
    out_ep_in.grant      = 1'b0;
    out_ep_in.data_avail = 1'b0;
  endtask

  task automatic user_drain(input int n);
    usb_ep_pkg::rx_beat_t exp;
    int                   got;
    got = 0;
    while (got < n) begin
      @(negedge clk);
      rx_ready = 1'b1;
      #1;
      if (rx_valid) begin
        check("rx beat expected", 1'b1, rx_exp_q.size() > 0);
        exp = rx_exp_q.pop_front();
        check("rx beat", exp, rx_beat);
        got++;
      end
    end
    @(negedge clk);
    rx_ready = 1'b0;
  endtask

  // pushes n bytes, or stops at the first refusal when asked to
  task automatic user_push(input int n, input logic stop_on_full, output int pushed);
    logic [31:0] r;
    logic [7:0]  b;
    pushed = 0;
    r      = lcg_next();
    b      = r[23:16];
    while (pushed < n) begin
      @(negedge clk);
      tx_valid = 1'b1;
      tx_data  = b;
      #1;
      if (tx_ready) begin
        tx_exp_q.push_back(b);
        pushed++;
        r = lcg_next();
        b = r[23:16];
      end else if (stop_on_full) begin
        break;
      end
    end
    @(negedge clk);
    tx_valid = 1'b0;
  endtask

  // packets close at every pkt-th byte and at the last one
  task automatic in_collect(input int n, input int pkt);
    logic [7:0] exp;
    int         got;
    got = 0;
    while (got < n) begin
      @(negedge clk);
      if (in_ep_out.data_put) begin
        check("in byte expected", 1'b1, tx_exp_q.size() > 0);
        exp = tx_exp_q.pop_front();
        check("in data", exp, in_ep_out.data);
        check("in done", ((got + 1) % pkt == 0) || (got == n - 1), in_ep_out.data_done);
        got++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset_and_regs();
    logic [31:0] rd;
    logic        err;
    test_name = "test_reset_and_regs";
    check("out req", 1'b0, out_ep_out.req);
    check("data_get", 1'b0, out_ep_out.data_get);
    check("out stall", 1'b0, out_ep_out.stall);
    check("in req", 1'b0, in_ep_out.req);
    check("data_put", 1'b0, in_ep_out.data_put);
    check("data_done", 1'b0, in_ep_out.data_done);
    check("in stall", 1'b0, in_ep_out.stall);
    check("rx_valid", 1'b0, rx_valid);
    check("tx_ready", 1'b1, tx_ready);
    check("pslverr idle", 1'b0, apb_rsp.pslverr);
    read_expect("ctrl", `USB_SERIAL_ADDR_CTRL, 32'd0);
    read_expect("maxpkt", `USB_SERIAL_ADDR_MAXPKT, 32'd32);
    read_expect("status", `USB_SERIAL_ADDR_STATUS, 32'd0);
    apb_write(`USB_SERIAL_ADDR_CTRL, 32'd1, err);
    check("ctrl write pslverr", 1'b0, err);
    apb_write(`USB_SERIAL_ADDR_MAXPKT, 32'd8, err);
    check("maxpkt write pslverr", 1'b0, err);
    read_expect("ctrl enabled", `USB_SERIAL_ADDR_CTRL, 32'd1);
    read_expect("maxpkt 8", `USB_SERIAL_ADDR_MAXPKT, 32'd8);
    // rejected writes
    apb_write(`USB_SERIAL_ADDR_MAXPKT, 32'd0, err);
    check("maxpkt 0 pslverr", 1'b1, err);
    apb_write(8'h20, 32'hffff_ffff, err);
    check("unmapped write pslverr", 1'b1, err);
    apb_access(8'h20, 1'b0, 32'd0, rd, err);
    check("unmapped read pslverr", 1'b1, err);
    read_expect("maxpkt kept", `USB_SERIAL_ADDR_MAXPKT, 32'd8);
    read_expect("ctrl kept", `USB_SERIAL_ADDR_CTRL, 32'd1);
  endtask

  task automatic test_out_path();
    test_name = "test_out_path";
    queue_out_beats(20);
    fork
      out_host();
      user_drain(20);
    join
    read_expect("rxcnt", `USB_SERIAL_ADDR_RXCNT, 32'd20);
  endtask

  task automatic test_out_backpressure();
    logic [31:0] rd;
    logic        err;
    test_name = "test_out_backpressure";
    queue_out_beats(30);
    fork
      out_host();
      begin
        // host still offering but the bridge stopped asking
        do begin
          @(negedge clk);
          #1;
        end while (!(out_ep_in.data_avail && !out_ep_out.req));
        // let the last byte in flight land
        repeat (2) @(negedge clk);
        apb_access(`USB_SERIAL_ADDR_STATUS, 1'b0, 32'd0, rd, err);
        check("req low while full", 1'b0, out_ep_out.req);
        check("bytes taken before stop", `USB_SERIAL_RX_DEPTH, out_sent);
        check("rx level at stop", out_sent, rd[14:8]);
        user_drain(30);
      end
    join
  endtask

  task automatic test_in_packets();
    logic err;
    int   pushed;
    test_name = "test_in_packets";
    apb_write(`USB_SERIAL_ADDR_MAXPKT, 32'd8, err);
    apb_write(`USB_SERIAL_ADDR_TXCNT, 32'd0, err);
    @(negedge clk);
    in_ep_in.data_free = 1'b1;
    fork
      user_push(19, 1'b0, pushed);
      in_collect(19, 8);
    join
    read_expect("txcnt", `USB_SERIAL_ADDR_TXCNT, 32'd19);
  endtask

  task automatic test_in_backpressure_and_stall();
    logic err;
    int   pushed;
    int   i;
    test_name = "test_in_backpressure_and_stall";
    @(negedge clk);
    in_ep_in.data_free = 1'b0;
    user_push(`USB_SERIAL_TX_DEPTH + 8, 1'b1, pushed);
    check("bytes taken until full", `USB_SERIAL_TX_DEPTH, pushed);
    check("tx_ready when full", 1'b0, tx_ready);
    read_expect("tx level full", `USB_SERIAL_ADDR_STATUS, `USB_SERIAL_TX_DEPTH);
    @(negedge clk);
    in_ep_in.data_free = 1'b1;
    in_collect(`USB_SERIAL_TX_DEPTH, 8);
    // leave a few bytes waiting, core not free
    @(negedge clk);
    in_ep_in.data_free = 1'b0;
    user_push(4, 1'b0, pushed);
    @(negedge clk);
    check("in req with bytes waiting", 1'b1, in_ep_out.req);
    apb_write(`USB_SERIAL_ADDR_CTRL, 32'd3, err);
    check("out stall set", 1'b1, out_ep_out.stall);
    check("in stall set", 1'b1, in_ep_out.stall);
    // stall kept, enable cleared
    apb_write(`USB_SERIAL_ADDR_CTRL, 32'd2, err);
    in_ep_in.data_free = 1'b1;
    for (i = 0; i < 10; i++) begin
      @(negedge clk);
      check("in req disabled", 1'b0, in_ep_out.req);
      check("no put while disabled", 1'b0, in_ep_out.data_put);
    end
    check("in stall kept", 1'b1, in_ep_out.stall);
    read_expect("tx level kept", `USB_SERIAL_ADDR_STATUS, 32'd4);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n       = 1'b0;
    out_ep_in   = '0;
    in_ep_in    = '0;
    tx_data     = 8'h00;
    tx_valid    = 1'b0;
    rx_ready    = 1'b0;
    apb_req     = '0;
    lcg_state   = 32'h49b79067;
    out_sent    = 0;
    cycle_count = 0;
    test_name   = "reset";
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    test_reset_and_regs();
    test_out_path();
    test_out_backpressure();
    test_in_packets();
    test_in_backpressure_and_stall();
    @(negedge clk);
    if (dut0.asserts0.fail_count != 0) begin
      $display("bound assertions failed %0d times", dut0.asserts0.fail_count);
      $display("Verification failed");
      $fatal(1, "assertion failures during the run");
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- tests/usb_serial_bridge_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_serial_settings.svh"

module usb_serial_bridge_asserts (
  input  wire  logic                          clk,
  input  wire  logic                          rst_n,
  input  wire  usb_ep_pkg::out_ep_out_t       out_ep_out,
  input  wire  usb_ep_pkg::in_ep_out_t        in_ep_out,
  input  wire  logic [`USB_SERIAL_LVL_W-1:0] rx_level,
  input  wire  usb_ep_pkg::rx_beat_t          rx_beat,
  input  wire  logic                          rx_valid,
  input  wire  logic                          rx_ready
);

  // property failures so far
  int fail_count;

  initial fail_count = 0;

  // put register is cleared by any reset cycle
  put_quiet_in_reset: assert property (@(posedge clk) !rst_n |=> !in_ep_out.data_put)
    else begin
      $error("data_put high after a reset cycle");
      fail_count++;
    end

  // done marks a byte, never stands alone
  done_with_put: assert property (@(posedge clk) disable iff (!rst_n)
    in_ep_out.data_done |-> in_ep_out.data_put)
    else begin
      $error("data_done without data_put");
      fail_count++;
    end

  // one byte may still be in flight, so req must stop one entry early
  req_room: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(out_ep_out.req) |-> (rx_level < (`USB_SERIAL_RX_DEPTH - 1)))
    else begin
      $error("out req rose with the receive fifo almost full");
      fail_count++;
    end

  // user side holds the beat until taken
  beat_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rx_valid && !rx_ready |=> $stable(rx_beat))
    else begin
      $error("rx_beat changed while waiting for rx_ready");
      fail_count++;
    end

endmodule

bind usb_serial_bridge usb_serial_bridge_asserts asserts0 (
  .clk        (clk),
  .rst_n      (rst_n),
  .out_ep_out (out_ep_out),
  .in_ep_out  (in_ep_out),
  .rx_level   (status.rx_level),
  .rx_beat    (rx_beat),
  .rx_valid   (rx_valid),
  .rx_ready   (rx_ready)
);

`default_nettype wire

//--- verilog/usb_serial_bridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_serial_settings.svh"

module usb_serial_bridge (
  input  wire  logic                    clk,
  input  wire  logic                    rst_n,
  input  wire  usb_ep_pkg::out_ep_in_t  out_ep_in,
  input  wire  usb_ep_pkg::in_ep_in_t   in_ep_in,
  input  wire  logic [7:0]              tx_data,
  input  wire  logic                    tx_valid,
  input  wire  logic                    rx_ready,
  input  wire  apb_pkg::apb_req_t       apb_req,
  output       usb_ep_pkg::out_ep_out_t out_ep_out,
  output       usb_ep_pkg::in_ep_out_t  in_ep_out,
  output       logic                    tx_ready,
  output       usb_ep_pkg::rx_beat_t    rx_beat,
  output       logic                    rx_valid,
  output       apb_pkg::apb_rsp_t       apb_rsp
);

  usb_ep_pkg::ep_cfg_t    cfg;
  usb_ep_pkg::ep_status_t status;

  // host to user, status fills the rx half
  out_ep_receiver out_rx0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .ep_in    (out_ep_in),
    .cfg      (cfg),
    .rx_ready (rx_ready),
    .ep_out   (out_ep_out),
    .rx_beat  (rx_beat),
    .rx_valid (rx_valid),
    .rx_level (status.rx_level),
    .rx_byte  (status.rx_byte)
  );

  // user to host, status fills the tx half
  in_ep_packetizer in_tx0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .ep_in    (in_ep_in),
    .cfg      (cfg),
    .tx_data  (tx_data),
    .tx_valid (tx_valid),
    .ep_out   (in_ep_out),
    .tx_ready (tx_ready),
    .tx_level (status.tx_level),
    .tx_byte  (status.tx_byte)
  );

  serial_ep_regs regs0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .status  (status),
    .apb_rsp (apb_rsp),
    .cfg     (cfg)
  );

endmodule

`default_nettype wire

//--- verilog/serial_ep_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_serial_settings.svh"

module serial_ep_regs (
  input  wire  logic                   clk,
  input  wire  logic                   rst_n,
  input  wire  apb_pkg::apb_req_t      apb_req,
  input  wire  usb_ep_pkg::ep_status_t status,
  output       apb_pkg::apb_rsp_t      apb_rsp,
  output       usb_ep_pkg::ep_cfg_t    cfg
);

  logic        access;
  logic        wr;
  logic        mapped;
  logic        sel_ctrl;
  logic        sel_maxpkt;
  logic        sel_status;
  logic        sel_txcnt;
  logic        sel_rxcnt;
  logic        pkt_bad;
  logic [31:0] rd_mux;

  logic        enable_q;
  logic        stall_q;
  logic [6:0]  max_pkt_q;
  logic [31:0] tx_cnt;
  logic [31:0] rx_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////////////////////

  // access phase only, setup phase has no effect
  assign access = apb_req.psel && apb_req.penable;
  assign wr     = access && apb_req.pwrite;

  assign sel_ctrl   = (apb_req.paddr == `USB_SERIAL_ADDR_CTRL);
  assign sel_maxpkt = (apb_req.paddr == `USB_SERIAL_ADDR_MAXPKT);
  assign sel_status = (apb_req.paddr == `USB_SERIAL_ADDR_STATUS);
  assign sel_txcnt  = (apb_req.paddr == `USB_SERIAL_ADDR_TXCNT);
  assign sel_rxcnt  = (apb_req.paddr == `USB_SERIAL_ADDR_RXCNT);
  assign mapped     = sel_ctrl || sel_maxpkt || sel_status || sel_txcnt || sel_rxcnt;

  // packet size must be 1 to 64
  assign pkt_bad = (apb_req.pwdata == 32'd0) || (apb_req.pwdata > 32'd64);

  ////////////////////////////////////////////////////////////////////////////
  // control registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      enable_q  <= 1'b0;
      stall_q   <= 1'b0;
      max_pkt_q <= 7'(`USB_SERIAL_MAX_PKT_DEFAULT);
    end else begin
      if (wr && sel_ctrl) begin
        enable_q <= apb_req.pwdata[0];
        stall_q  <= apb_req.pwdata[1];
      end
      // out of range write is rejected and flagged below
      if (wr && sel_maxpkt && !pkt_bad) begin
        max_pkt_q <= apb_req.pwdata[6:0];
      end
    end
  end

  assign cfg.enable  = enable_q;
  assign cfg.stall   = stall_q;
  assign cfg.max_pkt = max_pkt_q;

  ////////////////////////////////////////////////////////////////////////////
  // byte counters
  ////////////////////////////////////////////////////////////////////////////

  // any write clears, a clear beats a count in the same cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tx_cnt <= '0;
      rx_cnt <= '0;
    end else begin
      if (wr && sel_txcnt) begin
        tx_cnt <= '0;
      end else if (status.tx_byte) begin
        tx_cnt <= tx_cnt + 32'd1;
      end
      if (wr && sel_rxcnt) begin
        rx_cnt <= '0;
      end else if (status.rx_byte) begin
        rx_cnt <= rx_cnt + 32'd1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read data and response
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_mux = '0;
    case (apb_req.paddr)
      `USB_SERIAL_ADDR_CTRL:   rd_mux = {30'd0, stall_q, enable_q};
      `USB_SERIAL_ADDR_MAXPKT: rd_mux = {25'd0, max_pkt_q};
      `USB_SERIAL_ADDR_STATUS: rd_mux = {17'd0, status.rx_level, 1'b0, status.tx_level};
      `USB_SERIAL_ADDR_TXCNT:  rd_mux = tx_cnt;
      `USB_SERIAL_ADDR_RXCNT:  rd_mux = rx_cnt;
      default:                 rd_mux = '0;
    endcase
  end

  assign apb_rsp.prdata  = rd_mux;
  // never any wait state
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = access && (!mapped || (apb_req.pwrite && sel_maxpkt && pkt_bad));

endmodule

`default_nettype wire

//--- verilog/in_ep_packetizer.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_serial_settings.svh"

module in_ep_packetizer (
  input  wire  logic                          clk,
  input  wire  logic                          rst_n,
  input  wire  usb_ep_pkg::in_ep_in_t         ep_in,
  input  wire  usb_ep_pkg::ep_cfg_t           cfg,
  input  wire  logic [7:0]                    tx_data,
  input  wire  logic                          tx_valid,
  output       usb_ep_pkg::in_ep_out_t        ep_out,
  output       logic                          tx_ready,
  output       logic [`USB_SERIAL_LVL_W-1:0] tx_level,
  output       logic                          tx_byte
);

  logic [7:0] head_data;
  logic       fifo_empty;
  logic       fifo_full;
  logic       fifo_wr;
  logic       drain;
  logic       last_byte;
  logic [6:0] bytes_left;

  logic       req_q;
  logic       put_q;
  logic       done_q;
  logic [7:0] data_q;

  ////////////////////////////////////////////////////////////////////////////
  // user side into the transmit fifo
  ////////////////////////////////////////////////////////////////////////////

  assign tx_ready = !fifo_full;
  assign fifo_wr  = tx_valid && tx_ready;

  ep_fifo #(
    .payload_t (logic [7:0]),
    .DEPTH     (`USB_SERIAL_TX_DEPTH)
  ) tx_fifo0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_data     (tx_data),
    .wr_en       (fifo_wr),
    .rd_en       (drain),
    .rd_data     (head_data),
    .empty       (fifo_empty),
    .full        (fifo_full),
    .almost_full (),
    .level       (tx_level)
  );

  ////////////////////////////////////////////////////////////////////////////
  // drain and packet framing
  ////////////////////////////////////////////////////////////////////////////

  // move a byte when the core has room and the packet is still open
  assign drain = ep_in.grant && ep_in.data_free && cfg.enable && !fifo_empty &&
                 (bytes_left != '0);

  // close on the max_pkt-th byte, or when nothing sits behind the head
  // a byte being pushed this cycle keeps the packet open
  assign last_byte = (bytes_left == 7'd1) ||
                     ((tx_level <= `USB_SERIAL_LVL_W'(1)) && !fifo_wr);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bytes_left <= 7'(`USB_SERIAL_MAX_PKT_DEFAULT);
      req_q      <= 1'b0;
      put_q      <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      // request one cycle behind fifo state
      req_q  <= !fifo_empty && cfg.enable;
      put_q  <= drain;
      done_q <= drain && last_byte;
      // idle cycles and closed packets restart the count
      if (drain && !last_byte) begin
        bytes_left <= bytes_left - 1'b1;
      end else begin
        bytes_left <= cfg.max_pkt;
      end
    end
  end

  // byte handed to the core along with the put pulse
  always_ff @(posedge clk) begin
    if (drain) begin
      data_q <= head_data;
    end
  end

  assign ep_out.req       = req_q;
  assign ep_out.data_put  = put_q;
  assign ep_out.data      = data_q;
  assign ep_out.data_done = done_q;
  assign ep_out.stall     = cfg.stall;

  // one pulse per byte handed to the core
  assign tx_byte = put_q;

endmodule

`default_nettype wire

//--- verilog/out_ep_receiver.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_serial_settings.svh"

module out_ep_receiver (
  input  wire  logic                          clk,
  input  wire  logic                          rst_n,
  input  wire  usb_ep_pkg::out_ep_in_t        ep_in,
  input  wire  usb_ep_pkg::ep_cfg_t           cfg,
  input  wire  logic                          rx_ready,
  output       usb_ep_pkg::out_ep_out_t       ep_out,
  output       usb_ep_pkg::rx_beat_t          rx_beat,
  output       logic                          rx_valid,
  output       logic [`USB_SERIAL_LVL_W-1:0] rx_level,
  output       logic                          rx_byte
);

  usb_ep_pkg::rx_beat_t wr_beat;

  logic xfer;
  logic xfer_q;
  logic fifo_empty;
  logic fifo_full;
  logic fifo_afull;

  // two free entries cover the byte already in flight plus a new one
  assign ep_out.req      = ep_in.data_avail && cfg.enable && !fifo_full && !fifo_afull;
  // always ready to take what the core grants
  assign ep_out.data_get = ep_in.grant;
  assign ep_out.stall    = cfg.stall;

  assign xfer = ep_in.grant && ep_in.data_avail && ep_out.req;

  // core drives the byte one cycle after the transfer cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      xfer_q <= 1'b0;
    end else begin
      xfer_q <= xfer;
    end
  end

  assign wr_beat.setup = ep_in.setup;
  assign wr_beat.data  = ep_in.data;

  ep_fifo #(
    .payload_t (usb_ep_pkg::rx_beat_t),
    .DEPTH     (`USB_SERIAL_RX_DEPTH)
  ) rx_fifo0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_data     (wr_beat),
    .wr_en       (xfer_q),
    .rd_en       (rx_valid && rx_ready),
    .rd_data     (rx_beat),
    .empty       (fifo_empty),
    .full        (fifo_full),
    .almost_full (fifo_afull),
    .level       (rx_level)
  );

  // user side sees the fifo head directly
  assign rx_valid = !fifo_empty;
  // one pulse per byte landing in the fifo, feeds the rx counter
  assign rx_byte  = xfer_q;

endmodule

`default_nettype wire

//--- verilog/ep_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "usb_serial_settings.svh"

module ep_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 16
) (
  input  wire  logic                          clk,
  input  wire  logic                          rst_n,
  input  wire  payload_t                      wr_data,
  input  wire  logic                          wr_en,
  input  wire  logic                          rd_en,
  output       payload_t                      rd_data,
  output       logic                          empty,
  output       logic                          full,
  output       logic                          almost_full,
  output       logic [`USB_SERIAL_LVL_W-1:0] level
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  localparam logic [`USB_SERIAL_LVL_W-1:0] LVL_FULL = `USB_SERIAL_LVL_W'(DEPTH);
  localparam logic [`USB_SERIAL_LVL_W-1:0] LVL_AFULL = `USB_SERIAL_LVL_W'(DEPTH - 1);
  localparam logic [AW-1:0] PTR_LAST = AW'(DEPTH - 1);

  payload_t mem [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic          do_wr;
  logic          do_rd;

  // writes into a full fifo and reads from an empty one are dropped
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  assign empty       = (level == '0);
  assign full        = (level == LVL_FULL);
  // exactly one entry left
  assign almost_full = (level == LVL_AFULL);

  // head of the queue shows without a read, first word fall-through
  assign rd_data = mem[rd_ptr];

  ////////////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // pointers and fill level
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      // wrap by compare so that any depth works
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves the level alone
      if (do_wr && !do_rd) begin
        level <= level + 1'b1;
      end else if (do_rd && !do_wr) begin
        level <= level - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/apb_pkg.sv
`default_nettype none

package apb_pkg;

  // requester side of the register port
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  // completer side, no wait states are ever inserted
  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire

//--- verilog/usb_ep_pkg.sv
`default_nettype none

`include "usb_serial_settings.svh"

package usb_ep_pkg;

  // out endpoint, core to bridge
  typedef struct packed {
    logic       grant;
    logic       data_avail;
    logic       setup;
    logic [7:0] data;
    // acknowledge from the host, not used for resend
    logic       acked;
  } out_ep_in_t;

  // out endpoint, bridge to core
  typedef struct packed {
    logic req;
    logic data_get;
    logic stall;
  } out_ep_out_t;

  // in endpoint, core to bridge
  typedef struct packed {
    logic grant;
    logic data_free;
    logic acked;
  } in_ep_in_t;

  // in endpoint, bridge to core
  typedef struct packed {
    logic       req;
    logic       data_put;
    logic [7:0] data;
    logic       data_done;
    logic       stall;
  } in_ep_out_t;

  // one received byte with its setup flag
  typedef struct packed {
    logic       setup;
    logic [7:0] data;
  } rx_beat_t;

  // controls from the register block to both paths
  typedef struct packed {
    logic       enable;
    logic       stall;
    logic [6:0] max_pkt;
  } ep_cfg_t;

  // levels and per-byte pulses back to the register block
  typedef struct packed {
    logic [`USB_SERIAL_LVL_W-1:0] tx_level;
    logic [`USB_SERIAL_LVL_W-1:0] rx_level;
    logic                         tx_byte;
    logic                         rx_byte;
  } ep_status_t;

endpackage

`default_nettype wire

//--- verilog/usb_serial_settings.svh
`ifndef USB_SERIAL_SETTINGS_SVH
`define USB_SERIAL_SETTINGS_SVH

// fifo depths, in entries
`define USB_SERIAL_TX_DEPTH 64
`define USB_SERIAL_RX_DEPTH 16

// packet size after reset, in bytes
`define USB_SERIAL_MAX_PKT_DEFAULT 32

// fill level width, wide enough for the deeper fifo when full
`define USB_SERIAL_LVL_W 7

// register byte addresses on the apb port
`define USB_SERIAL_ADDR_CTRL   8'h00
`define USB_SERIAL_ADDR_MAXPKT 8'h04
`define USB_SERIAL_ADDR_STATUS 8'h08
`define USB_SERIAL_ADDR_TXCNT  8'h0C
`define USB_SERIAL_ADDR_RXCNT  8'h10

`endif
